// File: Makefile
VERILATOR ?= verilator
TOP ?= uart_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fails unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
hw/uart_pkg.sv
hw/synchronizer.sv
hw/uart_fifo.sv
hw/uart_receive.sv
hw/uart_transmit.sv
hw/uart_apb_regs.sv
hw/uart_top.sv
tb/uart_tb.sv

// File: hw/synchronizer.sv
// Two flop synchronizer
`timescale 1ns/1ps
`default_nettype none

module synchronizer
	#(parameter logic reset_state = 1'b0)
	(input logic clk,
	input logic reset,
	input logic data_in,
	output logic data_out);

	// First stage may go metastable
	logic meta;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			meta <= reset_state;
			data_out <= reset_state;
		end
		else
		begin
			meta <= data_in;
			data_out <= meta;
		end
	end
endmodule

`default_nettype wire

// File: hw/uart_apb_regs.sv
// APB register block
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs
	(input logic clk,
	input logic reset,
	input uart_pkg::apb_req_t apb_req,
	output uart_pkg::apb_resp_t apb_resp,
	output logic [uart_pkg::divisor_width-1:0] divisor,
	output logic tx_push,
	output logic [7:0] tx_wdata,
	input logic tx_full,
	input logic tx_busy,
	output logic rx_pop,
	input uart_pkg::rx_entry_t rx_rdata,
	input logic rx_empty,
	input logic rx_valid,
	input logic rx_entry_error,
	input logic rx_full);

	import uart_pkg::*;

	logic access;
	logic write_access;
	logic read_access;
	logic sel_status;
	logic sel_data;
	logic sel_divisor;
	logic rx_overflow;
	logic framing_error;
	logic status_read;

	// Second cycle of a transfer
	assign access = apb_req.psel & apb_req.penable;
	assign write_access = access & apb_req.pwrite;
	assign read_access = access & ~apb_req.pwrite;

	// Address decode
	assign sel_status = apb_req.paddr == addr_status;
	assign sel_data = apb_req.paddr == addr_data;
	assign sel_divisor = apb_req.paddr == addr_divisor;

	assign status_read = read_access & sel_status;

	// Zero wait states
	assign apb_resp.pready = 1'b1;

	// Unknown address flags an error in the access cycle
	assign apb_resp.pslverr = access & ~(sel_status | sel_data | sel_divisor);

	// Full transmit FIFO drops the write
	assign tx_push = write_access & sel_data & ~tx_full;
	assign tx_wdata = apb_req.pwdata[7:0];

	// Read of an empty receive FIFO pops nothing
	assign rx_pop = read_access & sel_data & ~rx_empty;

	// Read mux, zero outside a read access
	always_comb
	begin
		apb_resp.prdata = '0;
		if (read_access)
		begin
			if (sel_status)
				apb_resp.prdata = {27'b0, tx_busy, framing_error, rx_overflow, tx_full, ~rx_empty};
			else if (sel_data && !rx_empty)
				apb_resp.prdata = {23'b0, rx_rdata.framing_error, rx_rdata.character};
			else if (sel_divisor)
				apb_resp.prdata = {{(32 - divisor_width){1'b0}}, divisor};
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			divisor <= divisor_reset;
			rx_overflow <= 1'b0;
			framing_error <= 1'b0;
		end
		else
		begin
			// Values below 4 are kept as written
			if (write_access && sel_divisor)
				divisor <= apb_req.pwdata[divisor_width-1:0];

			// New events win over the clear on a STATUS read
			if (rx_valid && rx_full)
				rx_overflow <= 1'b1;
			else if (status_read)
				rx_overflow <= 1'b0;

			// Only entries that reach the FIFO count
			if (rx_valid && !rx_full && rx_entry_error)
				framing_error <= 1'b1;
			else if (status_read)
				framing_error <= 1'b0;
		end
	end
endmodule

`default_nettype wire

// File: hw/uart_fifo.sv
// Synchronous FIFO
`timescale 1ns/1ps
`default_nettype none

module uart_fifo
	#(parameter type payload_t = logic [7:0])
	(input logic clk,
	input logic reset,
	input logic push,
	input payload_t wdata,
	input logic pop,
	output payload_t rdata,
	output logic full,
	output logic empty);

	import uart_pkg::*;

	localparam int addr_width = $clog2(fifo_depth);

	payload_t mem[fifo_depth];
	logic [addr_width-1:0] wr_ptr;
	logic [addr_width-1:0] rd_ptr;
	logic [addr_width:0] count;
	logic do_push;
	logic do_pop;

	assign full = count == (addr_width + 1)'(fifo_depth);
	assign empty = count == '0;

	// Blocked requests are ignored
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// Head is visible whenever not empty
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == addr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == addr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;

			// Push and pop together leave the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end
endmodule

`default_nettype wire

// File: hw/uart_pkg.sv
// UART shared definitions
`default_nettype none

package uart_pkg;

	// Bit period counter and divisor register width
	localparam int divisor_width = 16;

	// Clock cycles per bit after reset
	localparam logic [divisor_width-1:0] divisor_reset = 16;

	// Entries in each FIFO
	localparam int fifo_depth = 8;

	// APB byte addresses of the registers
	localparam logic [7:0] addr_status = 8'h00;
	localparam logic [7:0] addr_data = 8'h04;
	localparam logic [7:0] addr_divisor = 8'h08;

	// Request side of the APB bus, driven by the master
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// Response side of the APB bus, driven by the slave
	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_resp_t;

	// One received character with its stop bit check
	typedef struct packed {
		logic [7:0] character;
		logic framing_error;
	} rx_entry_t;

endpackage

`default_nettype wire

// File: hw/uart_receive.sv
// Serial receiver
`timescale 1ns/1ps
`default_nettype none

module uart_receive
	(input logic clk,
	input logic reset,
	input logic uart_rx,
	input logic [uart_pkg::divisor_width-1:0] divisor,
	output logic rx_valid,
	output uart_pkg::rx_entry_t rx_entry);

	import uart_pkg::*;

	// One extra bit so that 1.5 divisor periods fit
	localparam int count_width = divisor_width + 1;

	typedef enum logic {
		wait_start,
		read_character
	} state_t;

	state_t state;
	state_t state_nxt;
	logic [count_width-1:0] sample_count;
	logic [count_width-1:0] sample_count_nxt;
	logic [3:0] bit_count;
	logic [3:0] bit_count_nxt;
	logic [divisor_width-1:0] period;
	logic [7:0] shift_reg;
	logic do_shift;
	logic rx_sync;

	// Serial line idles high, so the synchronizer resets to 1
	synchronizer #(.reset_state(1'b1)) rx_synchronizer (
		.clk(clk),
		.reset(reset),
		.data_in(uart_rx),
		.data_out(rx_sync));

	// Stop bit is sampled live in the cycle of rx_valid
	assign rx_entry.character = shift_reg;
	assign rx_entry.framing_error = ~rx_sync;

	always_comb
	begin
		state_nxt = state;
		sample_count_nxt = sample_count;
		bit_count_nxt = bit_count;
		rx_valid = 1'b0;
		do_shift = 1'b0;

		unique case (state)
			wait_start:
			begin
				if (!rx_sync)
				begin
					// Start edge seen, first sample lands mid data bit 0
					state_nxt = read_character;
					sample_count_nxt = {1'b0, divisor} + {2'b0, divisor[divisor_width-1:1]}
						- count_width'(1);
				end
			end

			read_character:
			begin
				if (sample_count == '0)
				begin
					sample_count_nxt = {1'b0, period} - count_width'(1);
					if (bit_count == 4'd8)
					begin
						// Mid stop bit, report the character
						state_nxt = wait_start;
						rx_valid = 1'b1;
						bit_count_nxt = '0;
					end
					else
					begin
						do_shift = 1'b1;
						bit_count_nxt = bit_count + 4'd1;
					end
				end
				else
					sample_count_nxt = sample_count - count_width'(1);
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= wait_start;
			sample_count <= '0;
			bit_count <= '0;
		end
		else
		begin
			state <= state_nxt;
			sample_count <= sample_count_nxt;
			bit_count <= bit_count_nxt;
		end
	end

	// Payload registers
	always_ff @(posedge clk)
	begin
		// Divisor held for the whole frame
		if (state == wait_start && !rx_sync)
			period <= divisor;

		// Data arrives LSB first
		if (do_shift)
			shift_reg <= {rx_sync, shift_reg[7:1]};
	end
endmodule

`default_nettype wire

// File: hw/uart_top.sv
// UART with APB interface
`timescale 1ns/1ps
`default_nettype none

module uart_top
	(input logic clk,
	input logic reset,
	input uart_pkg::apb_req_t apb_req,
	output uart_pkg::apb_resp_t apb_resp,
	input logic uart_rx,
	output logic uart_tx);

	import uart_pkg::*;

	logic [divisor_width-1:0] divisor;
	logic tx_push;
	logic [7:0] tx_wdata;
	logic [7:0] tx_data;
	logic tx_full;
	logic tx_empty;
	logic tx_ready;
	logic tx_busy;
	logic rx_pop;
	logic rx_valid;
	logic rx_full;
	logic rx_empty;
	rx_entry_t rx_entry;
	rx_entry_t rx_rdata;

	// Busy while a frame is on the line or bytes are queued
	assign tx_busy = ~tx_ready | ~tx_empty;

	uart_apb_regs regs (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_resp(apb_resp),
		.divisor(divisor),
		.tx_push(tx_push),
		.tx_wdata(tx_wdata),
		.tx_full(tx_full),
		.tx_busy(tx_busy),
		.rx_pop(rx_pop),
		.rx_rdata(rx_rdata),
		.rx_empty(rx_empty),
		.rx_valid(rx_valid),
		.rx_entry_error(rx_entry.framing_error),
		.rx_full(rx_full));

	// Transmit queue, popped on the transmitter handshake
	uart_fifo #(.payload_t(logic [7:0])) tx_fifo (
		.clk(clk),
		.reset(reset),
		.push(tx_push),
		.wdata(tx_wdata),
		.pop(~tx_empty & tx_ready),
		.rdata(tx_data),
		.full(tx_full),
		.empty(tx_empty));

	uart_transmit transmitter (
		.clk(clk),
		.reset(reset),
		.divisor(divisor),
		.tx_valid(~tx_empty),
		.tx_data(tx_data),
		.tx_ready(tx_ready),
		.uart_tx(uart_tx));

	uart_receive receiver (
		.clk(clk),
		.reset(reset),
		.uart_rx(uart_rx),
		.divisor(divisor),
		.rx_valid(rx_valid),
		.rx_entry(rx_entry));

	// Receive queue, a full FIFO drops the entry
	uart_fifo #(.payload_t(rx_entry_t)) rx_fifo (
		.clk(clk),
		.reset(reset),
		.push(rx_valid),
		.wdata(rx_entry),
		.pop(rx_pop),
		.rdata(rx_rdata),
		.full(rx_full),
		.empty(rx_empty));
endmodule

`default_nettype wire

// File: hw/uart_transmit.sv
// Serial transmitter
`timescale 1ns/1ps
`default_nettype none

module uart_transmit
	(input logic clk,
	input logic reset,
	input logic [uart_pkg::divisor_width-1:0] divisor,
	input logic tx_valid,
	input logic [7:0] tx_data,
	output logic tx_ready,
	output logic uart_tx);

	import uart_pkg::*;

	logic busy;
	logic [9:0] shift_reg;
	logic [3:0] bit_count;
	logic [divisor_width-1:0] cycle_count;
	logic [divisor_width-1:0] period;

	assign tx_ready = ~busy;

	// Line is the low bit of the frame register, all ones when idle
	assign uart_tx = shift_reg[0];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			shift_reg <= '1;
			bit_count <= '0;
			cycle_count <= '0;
		end
		else if (!busy)
		begin
			if (tx_valid)
			begin
				// Stop bit, data, start bit
				busy <= 1'b1;
				shift_reg <= {1'b1, tx_data, 1'b0};
				bit_count <= '0;
				cycle_count <= divisor - divisor_width'(1);
			end
		end
		else if (cycle_count == '0)
		begin
			// Next bit, refill with ones behind it
			shift_reg <= {1'b1, shift_reg[9:1]};
			bit_count <= bit_count + 4'd1;
			cycle_count <= period - divisor_width'(1);
		end
		else if (bit_count == 4'd9 && cycle_count == divisor_width'(1))
		begin
			// Last stop cycle is spent idle so the next frame follows with no gap
			busy <= 1'b0;
		end
		else
			cycle_count <= cycle_count - divisor_width'(1);
	end

	// Divisor captured once per frame
	always_ff @(posedge clk)
	begin
		if (!busy && tx_valid)
			period <= divisor;
	end
endmodule

`default_nettype wire

// File: tb/uart_tb.sv
// UART testbench
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

	import uart_pkg::*;

	// Status reads allowed in one polling loop
	localparam int poll_limit = 4000;

	// Negedges allowed for pready in one access cycle
	localparam int ready_limit = 16;

	logic clk;
	logic reset;
	apb_req_t apb_req;
	apb_resp_t apb_resp;
	logic uart_tx;
	logic uart_rx;
	logic serial_line;
	logic loopback;

	int error_count;
	int timeout_count;
	int cur_divisor;
	int unsigned rand_state;
	string current_test;

	// Bytes written to DATA in line order
	logic [7:0] tx_expect[$];

	// Receiver input comes from the serial driver or straight from the transmitter
	assign uart_rx = loopback ? uart_tx : serial_line;

	uart_top DUT (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_resp(apb_resp),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx));

	// 4 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Xorshift step for the burst characters
	function automatic int unsigned next_random(input int unsigned state);
		int unsigned x;
		x = state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			error_count++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Access cycle ends on the first negedge with pready high
	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (apb_resp.pready !== 1'b1 && cycles < ready_limit)
		begin
			@(negedge clk);
			cycles++;
		end
		assert (apb_resp.pready === 1'b1)
		else
		begin
			timeout_count++;
			$display("Timeout: pready stayed low during an APB access");
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		// Setup
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= 1'b1;
		apb_req.paddr <= addr;
		apb_req.pwdata <= data;
		// Access
		@(posedge clk);
		apb_req.penable <= 1'b1;
		wait_ready();
		@(posedge clk);
		apb_req <= '0;
		// Track what the DUT now holds
		if (addr == addr_divisor)
			cur_divisor = int'(data[divisor_width-1:0]);
		if (addr == addr_data)
			tx_expect.push_back(data[7:0]);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
		output logic err);
		@(posedge clk);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= 1'b0;
		apb_req.paddr <= addr;
		apb_req.pwdata <= '0;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		// Read data is combinational and taken mid access cycle
		wait_ready();
		data = apb_resp.prdata;
		err = apb_resp.pslverr;
		@(posedge clk);
		apb_req <= '0;
	endtask

	// One 8N1 frame at the current divisor
	task automatic send_frame(input logic [7:0] data, input logic stop_error);
		logic [9:0] frame;
		int half;
		frame = {~stop_error, data, 1'b0};
		half = cur_divisor / 2;
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			serial_line <= frame[i];
			if (i == 9 && stop_error)
			begin
				// Bad stop bit goes high right after the receiver samples it
				// so the tail of the frame is not taken as a new start bit
				repeat (half + 1) @(posedge clk);
				serial_line <= 1'b1;
				repeat (cur_divisor - half - 2) @(posedge clk);
			end
			else
				repeat (cur_divisor - 1) @(posedge clk);
		end
		// Short idle gap
		repeat (4) @(posedge clk);
	endtask

	// Decodes uart_tx at mid bit once the start bit is seen
	task automatic decode_frame();
		logic [7:0] data;
		logic stop;
		int period;
		period = cur_divisor;
		data = '0;
		for (int i = 0; i < 8; i++)
		begin
			repeat ((i == 0) ? period + period / 2 : period) @(negedge clk);
			data[i] = uart_tx;
		end
		repeat (period) @(negedge clk);
		stop = uart_tx;
		check_value("tx stop bit", 32'd1, {31'b0, stop});
		assert (tx_expect.size() != 0)
		else
		begin
			error_count++;
			$display("Transmitter sent byte %h that was never written", data);
		end
		if (tx_expect.size() != 0)
			check_value("tx monitor", {24'b0, tx_expect.pop_front()}, {24'b0, data});
	endtask

	// Line monitor
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (!reset && uart_tx === 1'b0)
				decode_frame();
		end
	end

	// Polls STATUS until tx_busy clears
	task automatic wait_tx_idle();
		logic [31:0] status;
		logic err;
		int polls;
		polls = 0;
		apb_read(addr_status, status, err);
		while (status[4] !== 1'b0 && polls < poll_limit)
		begin
			apb_read(addr_status, status, err);
			polls++;
		end
		assert (status[4] === 1'b0)
		else
		begin
			timeout_count++;
			$display("Timeout: transmitter still busy after %0d status reads", polls);
		end
		assert (tx_expect.size() == 0)
		else
		begin
			error_count++;
			$display("%0d written bytes never showed up on uart_tx", tx_expect.size());
		end
	endtask

	// Polls STATUS until rx_not_empty
	task automatic wait_rx_ready();
		logic [31:0] status;
		logic err;
		int polls;
		polls = 0;
		apb_read(addr_status, status, err);
		while (status[0] !== 1'b1 && polls < poll_limit)
		begin
			apb_read(addr_status, status, err);
			polls++;
		end
		assert (status[0] === 1'b1)
		else
		begin
			timeout_count++;
			$display("Timeout: no received character after %0d status reads", polls);
		end
	endtask

	// Random bytes through the transmitter and back into the receiver
	task automatic run_burst(input int count);
		logic [7:0] sent[$];
		logic [7:0] value;
		logic [31:0] data;
		logic err;
		@(posedge clk);
		loopback <= 1'b1;
		for (int i = 0; i < count; i++)
		begin
			rand_state = next_random(rand_state);
			value = rand_state[7:0];
			sent.push_back(value);
			apb_write(addr_data, {24'b0, value});
		end
		for (int i = 0; i < count; i++)
		begin
			wait_rx_ready();
			apb_read(addr_data, data, err);
			check_value(current_test, {24'b0, sent.pop_front()}, data);
		end
		wait_tx_idle();
		@(posedge clk);
		loopback <= 1'b0;
	endtask

	task automatic run_vectors();
		int fd;
		int code;
		int line_no;
		string line;
		string op;
		logic [31:0] arg;
		logic [31:0] expected;
		logic [31:0] data;
		logic err;
		logic bad_addr;
		fd = $fopen("tb/uart_vectors.txt", "r");
		if (fd == 0)
		begin
			error_count++;
			$display("Could not open tb/uart_vectors.txt");
			return;
		end
		line_no = 0;
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			line_no++;
			// Skip blank and comment lines
			if (code == 0 || line.len() < 2 || line[0] == "#")
				continue;
			code = $sscanf(line, "%s %h %h", op, arg, expected);
			current_test = $sformatf("%s line %0d", op, line_no);
			if (code != 3)
			begin
				error_count++;
				$display("Vector line %0d is malformed", line_no);
			end
			else if (op == "wr")
				apb_write(arg[7:0], expected);
			else if (op == "rd")
			begin
				apb_read(arg[7:0], data, err);
				// Only the three register addresses are legal
				bad_addr = arg[7:0] != addr_status && arg[7:0] != addr_data
					&& arg[7:0] != addr_divisor;
				check_value(current_test, expected, data);
				check_value({current_test, " pslverr"}, {31'b0, bad_addr}, {31'b0, err});
			end
			else if (op == "send")
				send_frame(arg[7:0], expected[0]);
			else if (op == "burst")
				run_burst(int'(arg));
			else if (op == "idle")
				wait_tx_idle();
			else
			begin
				error_count++;
				$display("Unknown operation %s on vector line %0d", op, line_no);
			end
		end
		$fclose(fd);
	endtask

	initial
	begin
		reset = 1'b1;
		apb_req = '0;
		serial_line = 1'b1;
		loopback = 1'b0;
		error_count = 0;
		timeout_count = 0;
		cur_divisor = int'(divisor_reset);
		rand_state = 14;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		run_vectors();
		repeat (20) @(posedge clk);
		$display("Errors %0d, timeouts %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// File: tb/uart_vectors.txt
# op argument expected, all values hex
# wr addr data | rd addr expected | send byte stop_error | burst count 0 | idle 0 0
# Registers after reset
rd 08 10
rd 00 00
wr 08 0c
rd 08 0c
rd 0c 00
# Transmit at divisor 12
wr 04 a5
wr 04 3c
wr 04 01
idle 0 0
rd 00 00
# Receive
send 5a 0
send c3 0
rd 00 01
rd 04 5a
rd 00 01
rd 04 c3
rd 00 00
rd 04 00
# Framing error
send 7e 1
rd 00 09
rd 00 01
rd 04 17e
rd 00 00
# Overflow, ninth frame is lost
send 11 0
send 12 0
send 13 0
send 14 0
send 15 0
send 16 0
send 17 0
send 18 0
send 19 0
rd 00 05
rd 00 01
rd 04 11
rd 04 12
rd 04 13
rd 04 14
rd 04 15
rd 04 16
rd 04 17
rd 04 18
rd 04 00
rd 00 00
# Loopback at divisor 7
wr 08 07
burst 6 0
rd 00 00
